// ==== hw/cpu7_pkg.sv ====
// cpu7 shared types: data words, opcodes, error codes, command and status records

`ifndef CPU7_PKG_SV
`define CPU7_PKG_SV

package cpu7_pkg;

	parameter int DEF_NUM_CORES = 4;	// up to 16
	parameter int DEF_STACK_DEPTH = 8;	// up to 16

	typedef logic [55:0] word_t;	// stack data word
	typedef logic [13:0] instr_t;	// two opcodes, low one runs first

	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_DEPTH = 7'h01,
		OP_DUP   = 7'h02,
		OP_DROP  = 7'h03,
		OP_EMPTY = 7'h04,
		OP_SWAP  = 7'h05,
		OP_OVER  = 7'h06,
		OP_ROT   = 7'h07,
		// unary, top replaced in place
		OP_COM   = 7'h10,
		OP_NOT   = 7'h11,
		OP_INC   = 7'h12,
		OP_DEC   = 7'h13,
		// binary, two pops and one push
		OP_GT    = 7'h20,
		OP_GTEQ  = 7'h21,
		OP_SM    = 7'h22,
		OP_SMEQ  = 7'h23,
		OP_EQ    = 7'h24,
		OP_NEQ   = 7'h25,
		OP_AND   = 7'h26,
		OP_OR    = 7'h27,
		OP_XOR   = 7'h28,
		OP_SHL   = 7'h29,
		OP_SHR   = 7'h2a,
		OP_ADD   = 7'h2b,
		OP_SUB   = 7'h2c
	} opcode_e;

	typedef enum logic [3:0] {
		ERR_NONE    = 4'h0,
		ERR_DSFULL  = 4'h1,
		ERR_DSEMPTY = 4'h2,
		ERR_DSINDEX = 4'h3,
		ERR_INVALID = 4'h4
	} err_e;

	typedef struct packed {
		logic [3:0] core;	// target core
		logic       is_instr;	// 0 means push of value
		word_t      value;	// instruction in bits 13:0
	} cmd_t;

	typedef struct packed {
		logic       idle;
		err_e       err;	// sticky until reset or next fault
		logic [4:0] depth;
		word_t      top;	// zero on empty stack
	} core_stat_t;

endpackage

`endif

// ==== hw/op_stack.sv ====
// data stack: indexed lifo with push, pop, peek, poke, clear and a registered read port
`timescale 1ns/1ps

module op_stack #(
	parameter int WIDTH = 56,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_clear,
	input  logic             i_push_en,
	input  logic             i_pop_en,
	input  logic             i_peek_en,
	input  logic             i_poke_en,
	input  logic [4:0]       i_index,	// 0 is the top
	input  logic [WIDTH-1:0] i_data,
	output logic [WIDTH-1:0] o_data,
	output logic             o_full,
	output logic             o_empty,
	output logic [4:0]       o_depth
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [4:0] cnt;
	logic [4:0] top_pos;
	logic [4:0] slot;	// addressed item for peek and poke
	logic [4:0] rd_slot;

	assign top_pos = cnt - 5'd1;
	assign slot = top_pos - i_index;
	assign rd_slot = i_pop_en ? top_pos : slot;

	assign o_full = cnt == 5'(DEPTH);
	assign o_empty = cnt == 5'd0;
	assign o_depth = cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= 5'd0;
		end else if (i_clear) begin
			cnt <= 5'd0;
		end else if (i_push_en) begin
			cnt <= cnt + 5'd1;
		end else if (i_pop_en) begin
			cnt <= cnt - 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_push_en)
			mem[cnt[AW-1:0]] <= i_data;
		if (i_poke_en)
			mem[slot[AW-1:0]] <= i_data;
		if (i_pop_en || i_peek_en)
			o_data <= mem[rd_slot[AW-1:0]];	// valid from next cycle
	end

	// the owning core checks bounds before it raises an enable
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		i_push_en |-> !o_full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		i_pop_en |-> !o_empty);
	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({i_clear, i_push_en, i_pop_en, i_peek_en, i_poke_en}));

endmodule

// ==== hw/stack_core.sv ====
// stack core: runs constant pushes and opcode pairs as single steps on its data stack
`timescale 1ns/1ps

module stack_core #(
	parameter int STACK_DEPTH = cpu7_pkg::DEF_STACK_DEPTH
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_push_en,
	input  logic                 i_instr_en,
	input  cpu7_pkg::word_t      i_value,
	output cpu7_pkg::core_stat_t o_stat
);

	import cpu7_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE, S_INSTR, S_INSTR_DONE,
		S_PUSH_PROC, S_POP_PROC, S_PEEK_PROC, S_POKE_PROC,
		S_DUP_STEP, S_OP1_STEP, S_OP2_STEP,
		S_SWAP_STEP, S_OVER_STEP, S_ROT_STEP, S_TOP_LOAD
	} state_e;

	state_e state;
	state_e next_state;	// return point of the procedure states
	err_e err;
	opcode_e opcode;
	instr_t icr;
	logic instr_cnt;	// high while the second opcode is pending
	logic [2:0] step;
	logic [4:0] n_q;	// swap index
	word_t r_a, r_b, r_c;
	word_t top_q;

	word_t stk_din, stk_dout;
	logic [4:0] stk_index, stk_depth;
	logic stk_full, stk_empty, idx_ok;
	logic stk_push, stk_pop, stk_peek, stk_poke, stk_clear;

	// enables only fire when the bound check passes
	assign idx_ok = stk_index < stk_depth;
	assign stk_push = (state == S_PUSH_PROC) && !stk_full;
	assign stk_pop = (state == S_POP_PROC) && !stk_empty;
	assign stk_peek = (state == S_PEEK_PROC) && idx_ok;
	assign stk_poke = (state == S_POKE_PROC) && idx_ok;
	assign stk_clear = (state == S_INSTR) && (opcode == OP_EMPTY);

	op_stack #(.WIDTH($bits(word_t)), .DEPTH(STACK_DEPTH)) u_stack (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_clear  (stk_clear),
		.i_push_en(stk_push),
		.i_pop_en (stk_pop),
		.i_peek_en(stk_peek),
		.i_poke_en(stk_poke),
		.i_index  (stk_index),
		.i_data   (stk_din),
		.o_data   (stk_dout),
		.o_full   (stk_full),
		.o_empty  (stk_empty),
		.o_depth  (stk_depth)
	);

	// large operands saturate to an index no legal depth reaches
	function automatic logic [4:0] to_index(word_t w);
		return (w > word_t'(31)) ? 5'd31 : w[4:0];
	endfunction

	function automatic word_t unary_op(opcode_e op, word_t x);
		case (op)
			OP_COM:  return ~x + word_t'(1);	// two's complement
			OP_NOT:  return ~x;
			OP_INC:  return x + word_t'(1);
			default: return x - word_t'(1);	// dec
		endcase
	endfunction

	function automatic word_t binary_op(opcode_e op, word_t a, word_t b);
		case (op)
			OP_GT:   return word_t'(a > b);
			OP_GTEQ: return word_t'(a >= b);
			OP_SM:   return word_t'(a < b);
			OP_SMEQ: return word_t'(a <= b);
			OP_EQ:   return word_t'(a == b);
			OP_NEQ:  return word_t'(a != b);
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SHL:  return a << b;
			OP_SHR:  return a >> b;
			OP_ADD:  return a + b;
			default: return a - b;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			next_state <= S_IDLE;
			err <= ERR_NONE;
			instr_cnt <= 1'b0;
			step <= 3'd0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_push_en) begin
						stk_din <= i_value;
						next_state <= S_IDLE;
						state <= S_PUSH_PROC;
					end else if (i_instr_en) begin
						icr <= instr_t'(i_value);
						opcode <= opcode_e'(i_value[6:0]);
						instr_cnt <= 1'b1;
						state <= S_INSTR;
					end
				end
				S_PUSH_PROC: begin
					if (stk_full) begin
						err <= ERR_DSFULL;
						state <= S_IDLE;
					end else begin
						top_q <= stk_din;
						state <= next_state;
					end
				end
				S_POP_PROC: begin
					if (stk_empty) begin
						err <= ERR_DSEMPTY;
						state <= S_IDLE;
					end else begin
						state <= next_state;
					end
				end
				S_PEEK_PROC, S_POKE_PROC: begin
					if (!idx_ok) begin
						err <= ERR_DSINDEX;
						state <= S_IDLE;
					end else begin
						state <= next_state;
					end
				end
				S_INSTR: begin
					state <= S_INSTR_DONE;
					next_state <= S_INSTR_DONE;
					case (opcode)
						OP_NOP, OP_EMPTY: ;	// clear is raised combinationally
						OP_DEPTH: begin
							stk_din <= word_t'(stk_depth) + word_t'(1);
							state <= S_PUSH_PROC;
						end
						OP_DROP: state <= S_POP_PROC;
						OP_DUP: begin
							stk_index <= 5'd0;
							next_state <= S_DUP_STEP;
							state <= S_PEEK_PROC;
						end
						OP_COM, OP_NOT, OP_INC, OP_DEC: begin
							stk_index <= 5'd0;
							next_state <= S_OP1_STEP;
							state <= S_PEEK_PROC;
						end
						OP_GT, OP_GTEQ, OP_SM, OP_SMEQ, OP_EQ, OP_NEQ, OP_AND,
						OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_ADD, OP_SUB: begin
							step <= 3'd3;
							state <= S_OP2_STEP;
						end
						OP_SWAP: begin
							step <= 3'd5;
							state <= S_SWAP_STEP;
						end
						OP_OVER: begin
							step <= 3'd3;
							state <= S_OVER_STEP;
						end
						OP_ROT: begin
							step <= 3'd6;
							state <= S_ROT_STEP;
						end
						default: begin
							err <= ERR_INVALID;
							state <= S_IDLE;
						end
					endcase
				end
				S_INSTR_DONE: begin
					if (instr_cnt) begin
						opcode <= opcode_e'(icr[13:7]);
						instr_cnt <= 1'b0;
						state <= S_INSTR;
					end else if (stk_empty) begin
						state <= S_IDLE;
					end else begin
						// refresh the top readout
						stk_index <= 5'd0;
						next_state <= S_TOP_LOAD;
						state <= S_PEEK_PROC;
					end
				end
				S_TOP_LOAD: begin
					top_q <= stk_dout;
					state <= S_IDLE;
				end
				S_DUP_STEP: begin
					stk_din <= stk_dout;
					next_state <= S_INSTR_DONE;
					state <= S_PUSH_PROC;
				end
				S_OP1_STEP: begin
					stk_din <= unary_op(opcode, stk_dout);
					next_state <= S_INSTR_DONE;
					state <= S_POKE_PROC;
				end
				S_OP2_STEP: begin
					next_state <= state;
					step <= step - 3'd1;
					case (step)
						3'd3: state <= S_POP_PROC;	// b
						3'd2: begin
							r_b <= stk_dout;
							state <= S_POP_PROC;	// a
						end
						3'd1: begin
							stk_din <= binary_op(opcode, stk_dout, r_b);
							state <= S_PUSH_PROC;
						end
						default: state <= S_INSTR_DONE;
					endcase
				end
				S_SWAP_STEP: begin
					next_state <= state;
					step <= step - 3'd1;
					case (step)
						3'd5: state <= S_POP_PROC;	// n
						3'd4: begin
							if (stk_dout == '0) begin
								state <= S_INSTR_DONE;
							end else begin
								stk_index <= to_index(stk_dout);
								n_q <= to_index(stk_dout);
								state <= S_PEEK_PROC;
							end
						end
						3'd3: begin
							r_b <= stk_dout;	// element n
							stk_index <= 5'd0;
							state <= S_PEEK_PROC;
						end
						3'd2: begin
							stk_din <= stk_dout;
							stk_index <= n_q;
							state <= S_POKE_PROC;
						end
						3'd1: begin
							stk_din <= r_b;
							stk_index <= 5'd0;
							state <= S_POKE_PROC;
						end
						default: state <= S_INSTR_DONE;
					endcase
				end
				S_OVER_STEP: begin
					next_state <= state;
					step <= step - 3'd1;
					case (step)
						3'd3: state <= S_POP_PROC;
						3'd2: begin
							stk_index <= to_index(stk_dout);
							state <= S_PEEK_PROC;
						end
						3'd1: begin
							stk_din <= stk_dout;
							state <= S_PUSH_PROC;
						end
						default: state <= S_INSTR_DONE;
					endcase
				end
				S_ROT_STEP: begin
					next_state <= state;
					step <= step - 3'd1;
					case (step)
						3'd6: begin
							if (stk_depth < 5'd3) begin
								err <= ERR_DSINDEX;
								state <= S_IDLE;
							end else begin
								state <= S_POP_PROC;
							end
						end
						3'd5: begin
							r_c <= stk_dout;
							state <= S_POP_PROC;
						end
						3'd4: begin
							r_b <= stk_dout;
							state <= S_POP_PROC;
						end
						3'd3: begin
							r_a <= stk_dout;
							stk_din <= r_b;
							state <= S_PUSH_PROC;
						end
						3'd2: begin
							stk_din <= r_c;
							state <= S_PUSH_PROC;
						end
						3'd1: begin
							stk_din <= r_a;	// old bottom ends on top
							state <= S_PUSH_PROC;
						end
						default: state <= S_INSTR_DONE;
					endcase
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign o_stat.idle = state == S_IDLE;
	assign o_stat.err = err;
	assign o_stat.depth = stk_depth;
	assign o_stat.top = stk_empty ? '0 : top_q;

	// dispatcher gates strobes with this core's idle level
	a_push_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		i_push_en |-> state == S_IDLE);

endmodule

// ==== hw/cmd_dispatch.sv ====
// command dispatcher: routes a command strobe to the idle core it addresses
`timescale 1ns/1ps

module cmd_dispatch #(
	parameter int NUM_CORES = cpu7_pkg::DEF_NUM_CORES
) (
	input  logic                 i_cmd_stb,
	input  cpu7_pkg::cmd_t       i_cmd,
	input  logic [NUM_CORES-1:0] i_idle,
	output logic                 o_cmd_rdy,
	output logic [NUM_CORES-1:0] o_push_en,
	output logic [NUM_CORES-1:0] o_instr_en,
	output cpu7_pkg::word_t      o_value
);

	logic in_range;
	logic [NUM_CORES-1:0] sel;	// one-hot target
	logic accept;

	assign in_range = int'(i_cmd.core) < NUM_CORES;
	assign sel = in_range ? (NUM_CORES'(1) << i_cmd.core) : '0;

	// out of range never goes ready
	assign o_cmd_rdy = |(sel & i_idle);
	assign accept = i_cmd_stb && o_cmd_rdy;

	assign o_push_en = (accept && !i_cmd.is_instr) ? sel : '0;
	assign o_instr_en = (accept && i_cmd.is_instr) ? sel : '0;
	assign o_value = i_cmd.value;	// broadcast, only the strobed core samples it

endmodule

// ==== hw/status_collect.sv ====
// status collector: registered cluster flags and readout of one selected core
`timescale 1ns/1ps

module status_collect #(
	parameter int NUM_CORES = cpu7_pkg::DEF_NUM_CORES
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  cpu7_pkg::core_stat_t [NUM_CORES-1:0] i_stat,
	input  logic [3:0]                           i_sel,
	output logic                                 o_all_idle,
	output logic [NUM_CORES-1:0]                 o_err_mask,
	output cpu7_pkg::core_stat_t                 o_sel_stat
);

	import cpu7_pkg::*;

	logic [NUM_CORES-1:0] idle_vec;
	logic [NUM_CORES-1:0] err_vec;
	core_stat_t sel_stat;

	always_comb begin
		sel_stat = '0;	// unknown core reads as zero
		for (int i = 0; i < NUM_CORES; i++) begin
			idle_vec[i] = i_stat[i].idle;
			err_vec[i] = i_stat[i].err != ERR_NONE;
			if (i_sel == 4'(i))
				sel_stat = i_stat[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_all_idle <= 1'b1;
			o_err_mask <= '0;
		end else begin
			o_all_idle <= &idle_vec;
			o_err_mask <= err_vec;
		end
	end

	always_ff @(posedge clk) begin
		o_sel_stat <= sel_stat;	// one cycle behind the cores
	end

endmodule

// ==== hw/cpu7_cluster.sv ====
// cpu7 cluster top: command dispatch into a row of stack cores with status collection
`timescale 1ns/1ps

module cpu7_cluster #(
	parameter int NUM_CORES = cpu7_pkg::DEF_NUM_CORES,
	parameter int STACK_DEPTH = cpu7_pkg::DEF_STACK_DEPTH
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_cmd_stb,
	input  cpu7_pkg::cmd_t       i_cmd,
	input  logic [3:0]           i_sel,
	output logic                 o_cmd_rdy,
	output logic                 o_all_idle,
	output logic [NUM_CORES-1:0] o_err_mask,
	output cpu7_pkg::core_stat_t o_sel_stat
);

	import cpu7_pkg::*;

	logic [NUM_CORES-1:0] push_en;
	logic [NUM_CORES-1:0] instr_en;
	logic [NUM_CORES-1:0] idle;
	word_t value;
	core_stat_t [NUM_CORES-1:0] stat;

	cmd_dispatch #(.NUM_CORES(NUM_CORES)) u_dispatch (
		.i_cmd_stb (i_cmd_stb),
		.i_cmd     (i_cmd),
		.i_idle    (idle),
		.o_cmd_rdy (o_cmd_rdy),
		.o_push_en (push_en),
		.o_instr_en(instr_en),
		.o_value   (value)
	);

	for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
		stack_core #(.STACK_DEPTH(STACK_DEPTH)) u_core (
			.clk       (clk),
			.rst_n     (rst_n),
			.i_push_en (push_en[g]),
			.i_instr_en(instr_en[g]),
			.i_value   (value),
			.o_stat    (stat[g])
		);
		assign idle[g] = stat[g].idle;	// feeds ready back to the dispatcher
	end

	status_collect #(.NUM_CORES(NUM_CORES)) u_collect (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_stat    (stat),
		.i_sel     (i_sel),
		.o_all_idle(o_all_idle),
		.o_err_mask(o_err_mask),
		.o_sel_stat(o_sel_stat)
	);

endmodule

// ==== verif/tb_cpu7_cluster.sv ====
// cluster testbench: table of commands with expected core status, applied through the dispatcher
`timescale 1ns/1ps

module tb_cpu7_cluster;

	import cpu7_pkg::*;

	localparam int NC = DEF_NUM_CORES;
	localparam int DEPTH = DEF_STACK_DEPTH;
	localparam logic PUSH = 1'b0;
	localparam logic INSTR = 1'b1;
	localparam int WAIT_MAX = 200;	// cycles per wait

	typedef struct {
		logic [3:0] core;
		logic       is_instr;
		word_t      value;
		word_t      top;	// expected after the command
		logic [4:0] depth;
		err_e       err;
	} row_t;

	logic clk;
	logic rst_n;
	logic cmd_stb;
	cmd_t cmd;
	logic [3:0] sel;
	logic cmd_rdy;
	logic all_idle;
	logic [NC-1:0] err_mask;
	core_stat_t sel_stat;

	row_t rows[$];
	word_t exp_top [NC];
	logic [4:0] exp_depth [NC];
	err_e exp_err [NC];
	logic [31:0] rng;
	int errors;
	int timeouts;

	cpu7_cluster UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_cmd_stb (cmd_stb),
		.i_cmd     (cmd),
		.i_sel     (sel),
		.o_cmd_rdy (cmd_rdy),
		.o_all_idle(all_idle),
		.o_err_mask(err_mask),
		.o_sel_stat(sel_stat)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] hi;
		hi = xorshift32(rng);
		rng = xorshift32(hi);
		return word_t'({hi, rng});
	endfunction

	// low slot runs first
	function automatic word_t ops(opcode_e first, opcode_e second);
		return word_t'({second, first});
	endfunction

	function automatic logic [NC-1:0] expected_mask();
		logic [NC-1:0] m;
		for (int i = 0; i < NC; i++)
			m[i] = exp_err[i] != ERR_NONE;
		return m;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_err(input string what, input err_e got, input err_e exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_depth(input string what, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input logic [NC-1:0] got, input logic [NC-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: error mask is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_idle(input string what, input logic got);
		if (got !== 1'b1) begin
			errors++;
			$display("Fail %0t: %s is %b, expected 1", $time, what, got);
		end
	endtask

	task automatic add_row(input logic [3:0] core, input logic is_instr, input word_t value,
			input word_t top, input logic [4:0] depth, input err_e err);
		row_t r;
		r.core = core;
		r.is_instr = is_instr;
		r.value = value;
		r.top = top;
		r.depth = depth;
		r.err = err;
		rows.push_back(r);
	endtask

	// readout is registered, two edges after the select changes
	task automatic check_core(input int c);
		sel = 4'(c);
		repeat (2) @(posedge clk);
		#1;
		check_idle($sformatf("core %0d idle", c), sel_stat.idle);
		check_word($sformatf("core %0d top", c), sel_stat.top, exp_top[c]);
		check_depth($sformatf("core %0d depth", c), sel_stat.depth, exp_depth[c]);
		check_err($sformatf("core %0d err", c), sel_stat.err, exp_err[c]);
	endtask

	task automatic wait_ready(output logic ok);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		while (!cmd_rdy && n < WAIT_MAX) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = cmd_rdy;
		if (!ok) begin
			timeouts++;
			$display("timeout: core %0d never became ready for a command", cmd.core);
		end
	endtask

	task automatic wait_idle(output logic ok);
		int n;
		n = 0;
		@(posedge clk);	// collector catches the busy core here
		#1;
		while (!all_idle && n < WAIT_MAX) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = all_idle;
		if (!ok) begin
			timeouts++;
			$display("timeout: cluster did not return to idle after a command to core %0d",
				cmd.core);
		end
	endtask

	task automatic send_row(input row_t r, output logic ok);
		cmd.core = r.core;
		cmd.is_instr = r.is_instr;
		cmd.value = r.value;
		wait_ready(ok);
		if (ok) begin
			cmd_stb = 1'b1;
			@(posedge clk);	// accepted on this edge
			#1;
			cmd_stb = 1'b0;
			wait_idle(ok);
		end
	endtask

	task automatic build_table();
		word_t x;
		word_t y;
		word_t res;
		// core 0 binary opcodes, a below b
		add_row(0, PUSH, 100, 100, 1, ERR_NONE);
		add_row(0, PUSH, 7, 7, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_ADD, OP_NOP), 107, 1, ERR_NONE);
		add_row(0, PUSH, 7, 7, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_SUB, OP_NOP), 100, 1, ERR_NONE);
		add_row(0, PUSH, 12, 12, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_AND, OP_NOP), 4, 1, ERR_NONE);
		add_row(0, PUSH, 3, 3, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_OR, OP_NOP), 7, 1, ERR_NONE);
		add_row(0, PUSH, 5, 5, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_XOR, OP_NOP), 2, 1, ERR_NONE);
		add_row(0, PUSH, 4, 4, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_SHL, OP_NOP), 32, 1, ERR_NONE);
		add_row(0, PUSH, 2, 2, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_SHR, OP_NOP), 8, 1, ERR_NONE);
		add_row(0, PUSH, 9, 9, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_GT, OP_NOP), 0, 1, ERR_NONE);	// 8 > 9
		add_row(0, PUSH, 0, 0, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_GTEQ, OP_NOP), 1, 1, ERR_NONE);
		add_row(0, PUSH, 1, 1, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_SM, OP_NOP), 0, 1, ERR_NONE);
		add_row(0, PUSH, 0, 0, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_SMEQ, OP_NOP), 1, 1, ERR_NONE);
		add_row(0, PUSH, 1, 1, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_EQ, OP_NOP), 1, 1, ERR_NONE);
		add_row(0, PUSH, 1, 1, 2, ERR_NONE);
		add_row(0, INSTR, ops(OP_NEQ, OP_NOP), 0, 1, ERR_NONE);
		// core 1 unary opcodes and both slots
		add_row(1, PUSH, 5, 5, 1, ERR_NONE);
		add_row(1, INSTR, ops(OP_INC, OP_NOP), 6, 1, ERR_NONE);
		add_row(1, INSTR, ops(OP_DEC, OP_DEC), 4, 1, ERR_NONE);
		add_row(1, INSTR, ops(OP_NOT, OP_NOP), 56'hff_ffff_ffff_fffb, 1, ERR_NONE);
		add_row(1, INSTR, ops(OP_COM, OP_NOP), 5, 1, ERR_NONE);	// negate
		add_row(1, INSTR, ops(OP_DUP, OP_ADD), 10, 1, ERR_NONE);
		add_row(1, PUSH, 3, 3, 2, ERR_NONE);
		add_row(1, INSTR, ops(OP_SUB, OP_INC), 8, 1, ERR_NONE);	// reversed would give 6
		// core 2 shuffles
		add_row(2, PUSH, 10, 10, 1, ERR_NONE);
		add_row(2, PUSH, 20, 20, 2, ERR_NONE);
		add_row(2, PUSH, 30, 30, 3, ERR_NONE);
		add_row(2, PUSH, 2, 2, 4, ERR_NONE);
		add_row(2, INSTR, ops(OP_SWAP, OP_NOP), 10, 3, ERR_NONE);	// 30 20 10
		add_row(2, PUSH, 0, 0, 4, ERR_NONE);
		add_row(2, INSTR, ops(OP_SWAP, OP_NOP), 10, 3, ERR_NONE);
		add_row(2, PUSH, 1, 1, 4, ERR_NONE);
		add_row(2, INSTR, ops(OP_OVER, OP_NOP), 20, 4, ERR_NONE);
		add_row(2, INSTR, ops(OP_DROP, OP_NOP), 10, 3, ERR_NONE);
		add_row(2, INSTR, ops(OP_ROT, OP_NOP), 30, 3, ERR_NONE);	// 20 10 30
		add_row(2, INSTR, ops(OP_DROP, OP_NOP), 10, 2, ERR_NONE);
		add_row(2, INSTR, ops(OP_DROP, OP_NOP), 20, 1, ERR_NONE);
		add_row(2, INSTR, ops(OP_DEPTH, OP_NOP), 2, 2, ERR_NONE);
		add_row(2, INSTR, ops(OP_EMPTY, OP_NOP), 0, 0, ERR_NONE);
		// core 3 faults, err stays until the next fault
		add_row(3, INSTR, ops(OP_DROP, OP_NOP), 0, 0, ERR_DSEMPTY);
		for (int i = 1; i <= DEPTH; i++)
			add_row(3, PUSH, word_t'(i), word_t'(i), 5'(i), ERR_DSEMPTY);
		add_row(3, PUSH, word_t'(DEPTH + 1), word_t'(DEPTH), 5'(DEPTH), ERR_DSFULL);
		add_row(3, INSTR, ops(OP_EMPTY, OP_NOP), 0, 0, ERR_DSFULL);
		add_row(3, INSTR, 56'h7f, 0, 0, ERR_INVALID);	// unused opcode
		// core 0 random operands
		add_row(0, INSTR, ops(OP_EMPTY, OP_NOP), 0, 0, ERR_NONE);
		for (int k = 0; k < 4; k++) begin
			x = rand_word();
			y = rand_word();
			res = (k % 2 == 0) ? x + y : x ^ y;
			add_row(0, PUSH, x, x, 1, ERR_NONE);
			add_row(0, PUSH, y, y, 2, ERR_NONE);
			add_row(0, INSTR, ops((k % 2 == 0) ? OP_ADD : OP_XOR, OP_NOP), res, 1, ERR_NONE);
			add_row(0, INSTR, ops(OP_DROP, OP_NOP), 0, 0, ERR_NONE);
		end
	endtask

	initial begin
		logic ok;
		row_t r;
		rst_n = 1'b0;
		cmd_stb = 1'b0;
		cmd = '0;
		sel = 4'd0;
		errors = 0;
		timeouts = 0;
		rng = 32'h7872_2a93;
		for (int c = 0; c < NC; c++) begin
			exp_top[c] = '0;
			exp_depth[c] = 5'd0;
			exp_err[c] = ERR_NONE;
		end
		build_table();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		if (all_idle !== 1'b1) begin
			errors++;
			$display("Fail %0t: cluster not idle after reset", $time);
		end
		check_mask(err_mask, '0);
		for (int c = 0; c < NC; c++)
			check_core(c);
		ok = 1'b1;
		for (int i = 0; i < rows.size() && ok; i++) begin
			r = rows[i];
			send_row(r, ok);
			if (ok) begin
				exp_top[r.core] = r.top;
				exp_depth[r.core] = r.depth;
				exp_err[r.core] = r.err;
				check_core(int'(r.core));
				check_mask(err_mask, expected_mask());
			end
		end
		// other cores must still hold their last state
		if (ok) begin
			for (int c = 0; c < NC; c++)
				check_core(c);
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== cpu7_cluster.f ====
hw/cpu7_pkg.sv
hw/op_stack.sv
hw/stack_core.sv
hw/cmd_dispatch.sv
hw/status_collect.sv
hw/cpu7_cluster.sv
verif/tb_cpu7_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cpu7_cluster -f cpu7_cluster.f \
	-Mdir obj_dir -o sim_cpu7 > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_cpu7 > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
